//--- common/cic_pkg.sv
`default_nettype none

package cic_pkg;

	// One signed input or output sample of either channel
	typedef logic signed [7:0] sample_t;

	// In-phase and quadrature samples carried together at the top level
	typedef struct packed {
		sample_t i;
		sample_t q;
	} iq_sample_t;

	// Decimation ratio as applied at runtime
	typedef logic [15:0] ratio_t;

	// Number of integrator stages and also of comb stages
	localparam int cic_order_default = 5;

	// Internal two's-complement word width
	// 8 input bits plus 5 stages of log2(16) growth each gives 28 bits
	localparam int cic_width_default = 28;

	// Largest ratio for which the default width holds the full gain
	localparam int max_ratio_default = 16;

endpackage

`default_nettype wire

//--- cic/cic_integrator.sv
`timescale 1ns/1ps
`default_nettype none

// Integrator half of the CIC filter
// Every stage runs at the input rate and wraps on overflow, which the comb
// section undoes as long as the word width covers the full filter gain
module cic_integrator #(
	parameter int order = cic_pkg::cic_order_default,
	parameter int width = cic_pkg::cic_width_default
) (
	input wire clk,
	input wire rst,
	input wire cic_pkg::sample_t din,
	output logic signed [width-1:0] acc
);

	// Input widened to the internal word with its sign kept
	logic signed [width-1:0] din_ext;

	// Running sums, index 0 is the stage that sees the input
	logic signed [width-1:0] acc_r [order];

	assign din_ext = {{(width - 8){din[7]}}, din};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int k = 0; k < order; k++)
			begin
				acc_r[k] <= '0;
			end
		end
		else
		begin
			// First stage accumulates the raw samples
			acc_r[0] <= acc_r[0] + din_ext;

			// Each later stage accumulates the stage in front of it
			for (int k = 1; k < order; k++)
			begin
				acc_r[k] <= acc_r[k] + acc_r[k-1];
			end
		end
	end

	// A sample shows up here order clocks after it enters
	assign acc = acc_r[order-1];

endmodule

`default_nettype wire

//--- cic/cic_comb.sv
`timescale 1ns/1ps
`default_nettype none

// Comb half of the CIC filter
// It only moves when advance is high, so it runs at the decimated rate
// while sharing the input clock with the integrators
module cic_comb #(
	parameter int order = cic_pkg::cic_order_default,
	parameter int width = cic_pkg::cic_width_default
) (
	input wire clk,
	input wire rst,
	input wire advance,
	input wire logic signed [width-1:0] din,
	output cic_pkg::sample_t dout,
	output logic out_valid
);

	import cic_pkg::*;

	// Differentiator outputs, index 0 is fed from din
	logic signed [width-1:0] stage_r [order];

	// Value each differentiator saw on the previous advance
	logic signed [width-1:0] dly_r [order];

	// Last stage scaled down to the output word
	logic signed [width-1:0] scaled_full;
	sample_t scaled;

	sample_t dout_r;
	logic valid_r;

	// Arithmetic shift keeps the top 8 bits of the internal word
	assign scaled_full = stage_r[order-1] >>> (width - 8);
	assign scaled = scaled_full[7:0];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int k = 0; k < order; k++)
			begin
				stage_r[k] <= '0;
				dly_r[k] <= '0;
			end
			dout_r <= '0;
		end
		else if (advance)
		begin
			// First differentiator works on the captured integrator word
			dly_r[0] <= din;
			stage_r[0] <= din - dly_r[0];

			for (int k = 1; k < order; k++)
			begin
				dly_r[k] <= stage_r[k-1];
				stage_r[k] <= stage_r[k-1] - dly_r[k];
			end

			// Output takes the last stage before it updates
			// so a captured value needs order+1 advances to reach dout
			dout_r <= scaled;
		end
	end

	// Valid follows advance by one clock, the cycle dout has just changed
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_r <= 1'b0;
		end
		else
		begin
			valid_r <= advance;
		end
	end

	assign dout = dout_r;
	assign out_valid = valid_r;

endmodule

`default_nettype wire

//--- cic/cic_channel.sv
`timescale 1ns/1ps
`default_nettype none

// One complete decimator channel
// Integrators run every clock, the capture strobe samples their output and
// the comb chain then works on the captured word one clock later
module cic_channel #(
	parameter int order = cic_pkg::cic_order_default,
	parameter int width = cic_pkg::cic_width_default
) (
	input wire clk,
	input wire rst,
	input wire capture,
	input wire cic_pkg::sample_t din,
	output cic_pkg::sample_t dout,
	output logic out_valid
);

	// Output of the last integrator stage
	logic signed [width-1:0] integ_acc;

	// Integrator word held for the comb between captures
	logic signed [width-1:0] cap_r;

	// Capture delayed by one clock so the comb sees the new cap_r
	logic advance_r;

	cic_integrator #(
		.order(order),
		.width(width)
	) u_integrator (
		.clk(clk),
		.rst(rst),
		.din(din),
		.acc(integ_acc)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cap_r <= '0;
			advance_r <= 1'b0;
		end
		else
		begin
			if (capture)
			begin
				cap_r <= integ_acc;
			end
			advance_r <= capture;
		end
	end

	cic_comb #(
		.order(order),
		.width(width)
	) u_comb (
		.clk(clk),
		.rst(rst),
		.advance(advance_r),
		.din(cap_r),
		.dout(dout),
		.out_valid(out_valid)
	);

endmodule

`default_nettype wire

//--- design/decim_timer.sv
`timescale 1ns/1ps
`default_nettype none

// Decimation timer shared by both channels
// Counts 0 to ratio-1 and wraps, so capture comes once every ratio clocks
module decim_timer (
	input wire clk,
	input wire rst,
	input wire cic_pkg::ratio_t ratio,
	output logic capture,
	output logic sample_clk
);

	import cic_pkg::*;

	ratio_t count_r;

	// Compare points derived from the runtime ratio
	ratio_t last_count;
	ratio_t half_count;

	logic wrap;
	logic overrun;
	logic clk_r;

	assign last_count = ratio - ratio_t'(1);
	assign half_count = ratio >> 1;

	assign wrap = (count_r == last_count);

	// Set when the ratio has been lowered below the current count
	assign overrun = (count_r > last_count);

	// Left combinational so that the channels register it themselves
	assign capture = wrap;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			count_r <= '0;
			clk_r <= 1'b0;
		end
		else if (overrun)
		begin
			// Restart the phase rather than count all the way round
			count_r <= '0;
		end
		else if (wrap)
		begin
			count_r <= '0;
			clk_r <= 1'b1;
		end
		else
		begin
			count_r <= count_r + ratio_t'(1);
			// Low again once half the period has gone by
			if (count_r == half_count)
			begin
				clk_r <= 1'b0;
			end
		end
	end

	assign sample_clk = clk_r;

endmodule

`default_nettype wire

//--- design/cic_iq_top.sv
`timescale 1ns/1ps
`default_nettype none

// Two-channel CIC decimator for I/Q baseband samples
// Both channels are driven from one timer so the outputs stay aligned
module cic_iq_top #(
	parameter int order = cic_pkg::cic_order_default,
	parameter int width = cic_pkg::cic_width_default
) (
	input wire clk,
	input wire rst,
	input wire cic_pkg::ratio_t ratio,
	input wire cic_pkg::iq_sample_t in_sample,
	output cic_pkg::iq_sample_t out_sample,
	output logic out_strobe,
	output logic d_clk
);

	import cic_pkg::*;

	logic capture;
	logic sample_clk;

	// Per-channel outputs before they are packed again
	sample_t dout_i;
	sample_t dout_q;
	logic strobe_i;

	logic d_clk_r;

	decim_timer u_timer (
		.clk(clk),
		.rst(rst),
		.ratio(ratio),
		.capture(capture),
		.sample_clk(sample_clk)
	);

	cic_channel #(
		.order(order),
		.width(width)
	) chan_i (
		.clk(clk),
		.rst(rst),
		.capture(capture),
		.din(in_sample.i),
		.dout(dout_i),
		.out_valid(strobe_i)
	);

	// Q valid matches I valid cycle for cycle so it is not brought out
	cic_channel #(
		.order(order),
		.width(width)
	) chan_q (
		.clk(clk),
		.rst(rst),
		.capture(capture),
		.din(in_sample.q),
		.dout(dout_q),
		.out_valid()
	);

	// One more register lines d_clk up with out_strobe
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			d_clk_r <= 1'b0;
		end
		else
		begin
			d_clk_r <= sample_clk;
		end
	end

	assign out_sample = '{i: dout_i, q: dout_q};
	assign out_strobe = strobe_i;
	assign d_clk = d_clk_r;

endmodule

`default_nettype wire

//--- bench/cic_iq_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for the two-channel CIC decimator
// A reference model follows the DUT every clock and predicts each output sample
module cic_iq_tb;

	import cic_pkg::*;

	localparam int order = cic_order_default;
	localparam int width = cic_width_default;
	localparam int max_ratio = max_ratio_default;
	localparam int clk_half = 4;
	localparam int reset_cycles = 8;
	localparam int num_tests = 5;

	typedef logic signed [width-1:0] word_t;

	typedef struct packed {
		ratio_t ratio;
		logic i_rand;
		sample_t i_val;
		logic q_rand;
		sample_t q_val;
		logic [7:0] samples;
		logic [7:0] skip;
		logic dc_check;
	} test_entry_t;

	logic clk;
	logic rst;
	ratio_t ratio;
	iq_sample_t in_sample;
	iq_sample_t out_sample;
	logic out_strobe;
	logic d_clk;

	test_entry_t tests [num_tests];
	string test_names [num_tests];
	logic table_ready;

	// Model state, row 0 is the I channel and row 1 the Q channel
	word_t integ [2][order];
	// Last integrator stage over the last three clocks, newest first
	word_t integ_hist [2][3];
	word_t comb_dly [2][order];
	// Comb results waiting to reach the output register
	word_t out_line [2][order];

	cic_iq_top #(
		.order(order),
		.width(width)
	) UUT (
		.clk(clk),
		.rst(rst),
		.ratio(ratio),
		.in_sample(in_sample),
		.out_sample(out_sample),
		.out_strobe(out_strobe),
		.d_clk(d_clk)
	);

	always #clk_half clk = ~clk;

	// Integrators at the input rate, walked backwards so each stage adds the old value
	always @(posedge clk)
	begin
		if (rst)
		begin
			for (int k = 0; k < order; k++)
			begin
				integ[0][k] = '0;
				integ[1][k] = '0;
			end
		end
		else
		begin
			for (int k = order - 1; k > 0; k--)
			begin
				integ[0][k] = integ[0][k] + integ[0][k-1];
				integ[1][k] = integ[1][k] + integ[1][k-1];
			end
			integ[0][0] = integ[0][0] + word_t'(in_sample.i);
			integ[1][0] = integ[1][0] + word_t'(in_sample.q);
		end
	end

	function automatic test_entry_t make_entry(int r, logic ir, int iv, logic qr, int qv,
		int n, int s, logic dc);
		test_entry_t e;
		e.ratio = ratio_t'(r);
		e.i_rand = ir;
		e.i_val = sample_t'(iv);
		e.q_rand = qr;
		e.q_val = sample_t'(qv);
		e.samples = 8'(n);
		e.skip = 8'(s);
		e.dc_check = dc;
		return e;
	endfunction

	function automatic sample_t next_value(logic rnd, sample_t fixed);
		logic [31:0] r;
		if (rnd)
		begin
			r = $urandom;
			return sample_t'(r[7:0]);
		end
		return fixed;
	endfunction

	function automatic sample_t scale_word(word_t w);
		word_t s;
		s = w >>> (width - 8);
		return s[7:0];
	endfunction

	// Steady output for a constant input is x times R to the order, then scaled
	function automatic sample_t dc_level(sample_t x, int r);
		longint p;
		p = longint'(x);
		for (int k = 0; k < order; k++)
		begin
			p = p * longint'(r);
		end
		p = p >>> (width - 8);
		return sample_t'(p[7:0]);
	endfunction

	task automatic load_table();
		tests[0] = make_entry(8, 1'b0, 64, 1'b0, -96, 6, 14, 1'b1);
		tests[1] = make_entry(5, 1'b1, 0, 1'b0, 17, 16, 2, 1'b0);
		tests[2] = make_entry(2, 1'b0, -3, 1'b1, 0, 16, 2, 1'b0);
		tests[3] = make_entry(16, 1'b0, 40, 1'b0, -25, 6, 14, 1'b1);
		tests[4] = make_entry(4, 1'b1, 0, 1'b0, -70, 16, 2, 1'b0);
		test_names[0] = "dc_r8";
		test_names[1] = "rand_i_r5";
		test_names[2] = "rand_q_r2";
		test_names[3] = "dc_r16";
		test_names[4] = "step_r16_to_r4";
		table_ready = 1'b1;
	endtask

	task automatic clear_model();
		for (int c = 0; c < 2; c++)
		begin
			for (int k = 0; k < order; k++)
			begin
				comb_dly[c][k] = '0;
				out_line[c][k] = '0;
			end
			for (int h = 0; h < 3; h++)
			begin
				integ_hist[c][h] = '0;
			end
		end
	endtask

	// One comb advance on a captured word, the result leaves the line order advances later
	task automatic comb_advance(input int c, input word_t x, output sample_t expected);
		word_t v;
		word_t t;
		v = x;
		for (int k = 0; k < order; k++)
		begin
			t = v - comb_dly[c][k];
			comb_dly[c][k] = v;
			v = t;
		end
		expected = scale_word(out_line[c][order-1]);
		for (int k = order - 1; k > 0; k--)
		begin
			out_line[c][k] = out_line[c][k-1];
		end
		out_line[c][0] = v;
	endtask

	// The strobe trails the capture by two clocks, so the captured word is two clocks old
	task automatic model_step(output sample_t exp_i, output sample_t exp_q);
		for (int c = 0; c < 2; c++)
		begin
			integ_hist[c][2] = integ_hist[c][1];
			integ_hist[c][1] = integ_hist[c][0];
			integ_hist[c][0] = integ[c][order-1];
		end
		exp_i = '0;
		exp_q = '0;
		if (out_strobe)
		begin
			comb_advance(0, integ_hist[0][2], exp_i);
			comb_advance(1, integ_hist[1][2], exp_q);
		end
	endtask

	task automatic stop_run();
		$display("test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_sample(string name, string field, sample_t expected, sample_t actual);
		assert (actual == expected)
		else
		begin
			$display("[FAIL] %s %s expected %0d actual %0d", name, field, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_bit(string name, string field, logic expected, logic actual);
		assert (actual == expected)
		else
		begin
			$display("[FAIL] %s %s expected %0b actual %0b", name, field, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_count(string name, string field, int expected, int actual);
		assert (actual == expected)
		else
		begin
			$display("[FAIL] %s %s expected %0d actual %0d", name, field, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_true(logic ok, string what);
		assert (ok)
		else
		begin
			$display("Error: %s", what);
			stop_run();
		end
	endtask

	initial
	begin
		string name;
		int cur_ratio;
		int prev_ratio;
		int half;
		int target;
		int first_limit;
		int n_strobe;
		int since;
		int cycles;
		sample_t exp_i;
		sample_t exp_q;
		sample_t dc_i;
		sample_t dc_q;
		iq_sample_t next_in;

		void'($urandom(32'h57c7));
		clk = 1'b0;
		rst = 1'b1;
		in_sample = '0;
		load_table();
		ratio = tests[0].ratio;
		clear_model();

		// Release comes on the last reset edge so the following check sees the idle state
		for (int c = 0; c < reset_cycles; c++)
		begin
			@(posedge clk);
			if (c == reset_cycles - 1)
			begin
				rst <= 1'b0;
			end
			in_sample <= '0;
			@(negedge clk);
			model_step(exp_i, exp_q);
			check_bit("reset", "out_strobe", 1'b0, out_strobe);
			check_bit("reset", "d_clk", 1'b0, d_clk);
			check_sample("reset", "out_sample.i", 8'sd0, out_sample.i);
			check_sample("reset", "out_sample.q", 8'sd0, out_sample.q);
		end

		prev_ratio = 0;
		for (int e = 0; e < num_tests; e++)
		begin
			name = test_names[e];
			cur_ratio = int'(tests[e].ratio);
			half = cur_ratio / 2;
			target = int'(tests[e].samples) + int'(tests[e].skip);
			first_limit = ((cur_ratio > prev_ratio) ? cur_ratio : prev_ratio) + 2;
			dc_i = dc_level(tests[e].i_val, cur_ratio);
			dc_q = dc_level(tests[e].q_val, cur_ratio);
			n_strobe = 0;
			since = 0;
			cycles = 0;
			check_true(cur_ratio >= 2 && cur_ratio <= max_ratio,
				"a table entry has a ratio outside the supported range");

			while (n_strobe < target)
			begin
				@(posedge clk);
				if (cycles == 0)
				begin
					ratio <= tests[e].ratio;
				end
				next_in.i = next_value(tests[e].i_rand, tests[e].i_val);
				next_in.q = next_value(tests[e].q_rand, tests[e].q_val);
				in_sample <= next_in;

				@(negedge clk);
				cycles++;
				since++;
				model_step(exp_i, exp_q);

				if (out_strobe)
				begin
					// The first two strobes may still carry the previous ratio's timing
					if (n_strobe >= 2)
					begin
						check_count(name, "strobe spacing", cur_ratio, since);
					end
					since = 0;
					n_strobe++;
					check_sample(name, "out_sample.i", exp_i, out_sample.i);
					check_sample(name, "out_sample.q", exp_q, out_sample.q);
					if (tests[e].dc_check && n_strobe > int'(tests[e].skip))
					begin
						check_sample(name, "dc level i", dc_i, out_sample.i);
						check_sample(name, "dc level q", dc_q, out_sample.q);
					end
				end
				else if (n_strobe == 0)
				begin
					check_true(cycles < first_limit,
						"no out_strobe arrived after the ratio was applied");
				end
				else if (n_strobe >= 2)
				begin
					check_true(since < cur_ratio, "an out_strobe pulse went missing");
				end

				// d_clk is high from the strobe cycle for half the ratio plus one clock
				if (n_strobe >= 2)
				begin
					check_bit(name, "d_clk", since <= half, d_clk);
				end
			end
			prev_ratio = cur_ratio;
		end

		$display("test passed");
		$finish;
	end

	// Watchdog sized from the table
	initial
	begin
		int budget;
		wait (table_ready === 1'b1);
		budget = reset_cycles;
		for (int e = 0; e < num_tests; e++)
		begin
			budget += int'(tests[e].ratio) * (int'(tests[e].samples) + int'(tests[e].skip)) + 20;
		end
		repeat (budget) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clocks", budget);
		$display("test failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- tb.f
common/cic_pkg.sv
cic/cic_integrator.sv
cic/cic_comb.sv
cic/cic_channel.sv
design/decim_timer.sv
design/cic_iq_top.sv
bench/cic_iq_tb.sv

//--- Makefile
# Verilator build and run for the CIC I/Q decimator testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP ?= cic_iq_tb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
JOBS ?= 0
VFLAGS ?= --binary --assert -j $(JOBS)
FAIL_TEXT ?= test failed
PASS_TEXT ?= test passed

SIM_BIN := $(BUILD_DIR)/$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

# The log decides the result, a fail line or a missing pass line fails the target
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG); \
	if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi; \
	if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
